//--- hdl/Core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and address width
`define XLEN 32
// architectural registers, x0 included
`define REG_COUNT 32
// memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

`endif

//--- hdl/CoreTypes.sv
package CoreTypes;

  // ##########################################################################
  // instruction classes
  // ##########################################################################

  typedef enum logic [2:0] {
    RType,       // register-register alu ops
    IType,       // register-immediate alu ops
    LoadType,    // lw
    StoreType,   // sw
    BranchType,  // beq, bne
    JumpType,    // jal
    UpperType,   // lui
    Illegal      // anything not in the subset
  } InstructionTypes;

  // refines the class, shared by R and I types and by branches
  typedef enum logic [3:0] {
    Add, Sub, And, Or, Xor, Slt, Sll, Srl, Sra,
    Beq, Bne,
    None  // no refinement needed
  } InstructionSubTypes;

  // ##########################################################################
  // datapath controls
  // ##########################################################################

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor,
    AluSlt,   // signed compare
    AluSll, AluSrl,
    AluSra,   // arithmetic shift
    AluPassB  // operand b straight through
  } AluOps;

  typedef enum logic [2:0] {
    ResAlu,      // alu result
    ResMem,      // load data
    ResPcPlus4,  // link address
    ResImm       // upper immediate
  } ResultSources;

endpackage

//--- hdl/InstructionDecode.sv
module InstructionDecode (
  input  logic [6:0]                     opCode,
  input  logic [2:0]                     funct3,
  input  logic [6:0]                     funct7,
  output CoreTypes::InstructionTypes     instructionType,
  output CoreTypes::InstructionSubTypes  instructionSubType
);
  import CoreTypes::*;

  logic f7Zero;  // funct7 all clear
  logic f7Alt;   // funct7 of 0100000 selects sub / sra

  assign f7Zero = (funct7 == 7'b0000000);
  assign f7Alt  = (funct7 == 7'b0100000);

  always_comb begin
    instructionType    = Illegal;  // unknown encodings fall through
    instructionSubType = None;
    case (opCode)
      7'b0110011: begin  // op
        instructionType = RType;
        case (funct3)
          3'b000:  instructionSubType = f7Alt ? Sub : Add;
          3'b111:  instructionSubType = And;
          3'b110:  instructionSubType = Or;
          3'b100:  instructionSubType = Xor;
          3'b010:  instructionSubType = Slt;
          3'b001:  instructionSubType = Sll;
          3'b101:  instructionSubType = f7Alt ? Sra : Srl;
          default: instructionType    = Illegal;  // sltu not supported
        endcase
        // only add/sub and srl/sra may carry the alternate funct7
        if (!(f7Zero || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          instructionType    = Illegal;
          instructionSubType = None;
        end
      end
      7'b0010011: begin  // op-imm where funct7 only matters for shifts
        instructionType = IType;
        case (funct3)
          3'b000:  instructionSubType = Add;
          3'b111:  instructionSubType = And;
          3'b110:  instructionSubType = Or;
          3'b100:  instructionSubType = Xor;
          3'b010:  instructionSubType = Slt;
          3'b001:  instructionSubType = Sll;
          3'b101:  instructionSubType = f7Alt ? Sra : Srl;
          default: instructionType    = Illegal;  // sltiu not supported
        endcase
      end
      7'b0000011: if (funct3 == 3'b010) instructionType = LoadType;   // lw only
      7'b0100011: if (funct3 == 3'b010) instructionType = StoreType;  // sw only
      7'b1100011: begin  // branch
        if (funct3 == 3'b000) begin
          instructionType    = BranchType;
          instructionSubType = Beq;
        end else if (funct3 == 3'b001) begin
          instructionType    = BranchType;
          instructionSubType = Bne;
        end
      end
      7'b1101111: instructionType = JumpType;   // jal
      7'b0110111: instructionType = UpperType;  // lui
      default: ;
    endcase
  end

endmodule

//--- hdl/ImmDecode.sv
`include "Core_consts.svh"

module ImmDecode (
  input  CoreTypes::InstructionTypes  instructionType,
  input  logic [`XLEN-1:0]            instruction,
  output logic [`XLEN-1:0]            immExt
);
  import CoreTypes::*;

  logic sign;  // every format takes its sign from bit 31
  assign sign = instruction[31];

  // shift amounts ride in the low five bits of the I form, the alu ignores the rest
  always_comb begin
    case (instructionType)
      IType, LoadType:
        immExt = {{(`XLEN-12){sign}}, instruction[31:20]};
      StoreType:
        immExt = {{(`XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
      BranchType:  // byte offset, lsb always zero
        immExt = {{(`XLEN-13){sign}}, sign, instruction[7], instruction[30:25],
                  instruction[11:8], 1'b0};
      JumpType:
        immExt = {{(`XLEN-21){sign}}, sign, instruction[19:12], instruction[20],
                  instruction[30:21], 1'b0};
      UpperType:
        immExt = {instruction[31:12], 12'b0};  // low 12 bits cleared
      default:
        immExt = '0;  // R type and illegal have no immediate
    endcase
  end

endmodule

//--- hdl/ControlDecode.sv
module ControlDecode (
  input  CoreTypes::InstructionTypes     instructionType,
  input  CoreTypes::InstructionSubTypes  instructionSubType,
  input  logic                           zero,
  output CoreTypes::ResultSources        resultSrc,
  output logic                           aluSrc,
  output logic                           pcSrc,
  output logic                           regWrite,
  output logic                           memWrite
);
  import CoreTypes::*;

  logic branchTaken;  // beq on equal, bne on not equal

  assign branchTaken = ((instructionSubType == Beq) &&  zero) ||
                       ((instructionSubType == Bne) && !zero);

  always_comb begin
    resultSrc = ResAlu;  // defaults write nothing and fall through
    aluSrc    = 1'b0;
    pcSrc     = 1'b0;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    case (instructionType)
      RType: regWrite = 1'b1;
      IType: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;  // immediate operand
      end
      LoadType: begin
        regWrite  = 1'b1;
        aluSrc    = 1'b1;  // base + offset
        resultSrc = ResMem;
      end
      StoreType: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      BranchType: pcSrc = branchTaken;  // alu subtracts, zero flags equality
      JumpType: begin
        regWrite  = 1'b1;
        resultSrc = ResPcPlus4;  // link
        pcSrc     = 1'b1;
      end
      UpperType: begin
        regWrite  = 1'b1;
        aluSrc    = 1'b1;
        resultSrc = ResImm;
      end
      default: ;  // illegal has no side effects
    endcase
  end

endmodule

//--- hdl/AluEncode.sv
module AluEncode (
  input  CoreTypes::InstructionTypes     instructionType,
  input  CoreTypes::InstructionSubTypes  instructionSubType,
  output CoreTypes::AluOps               aluControl
);
  import CoreTypes::*;

  AluOps subTypeOp;  // alu op named by the sub-type

  always_comb begin
    case (instructionSubType)
      Sub:     subTypeOp = AluSub;
      And:     subTypeOp = AluAnd;
      Or:      subTypeOp = AluOr;
      Xor:     subTypeOp = AluXor;
      Slt:     subTypeOp = AluSlt;
      Sll:     subTypeOp = AluSll;
      Srl:     subTypeOp = AluSrl;
      Sra:     subTypeOp = AluSra;
      default: subTypeOp = AluAdd;
    endcase
  end

  always_comb begin
    case (instructionType)
      RType, IType: aluControl = subTypeOp;
      BranchType:   aluControl = AluSub;    // compare by subtraction
      UpperType:    aluControl = AluPassB;  // immediate straight through
      default:      aluControl = AluAdd;    // address calc for lw / sw
    endcase
  end

endmodule

//--- hdl/ControlPath.sv
`include "Core_consts.svh"

module ControlPath (
  input  logic [`XLEN-1:0]        instruction,
  input  logic                    zero,
  output logic [`XLEN-1:0]        immExt,
  output CoreTypes::AluOps        aluControl,
  output CoreTypes::ResultSources resultSrc,
  output logic                    aluSrc,
  output logic                    pcSrc,
  output logic                    memWrite,
  output logic                    regWrite,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  output logic [4:0]              rd
);
  import CoreTypes::*;

  // ##########################################################################
  // instruction fields
  // ##########################################################################

  logic [6:0] opCode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opCode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];
  assign rs1    = instruction[19:15];
  assign rs2    = instruction[24:20];
  assign rd     = instruction[11:7];

  InstructionTypes    instructionType;     // shared by all three decoders below
  InstructionSubTypes instructionSubType;

  // ##########################################################################
  // decoders
  // ##########################################################################

  InstructionDecode instructionDecoder (
    .opCode(opCode), .funct3(funct3), .funct7(funct7),
    .instructionType(instructionType), .instructionSubType(instructionSubType)
  );

  ImmDecode immDecoder (.instructionType(instructionType), .instruction(instruction),
                        .immExt(immExt));

  ControlDecode controlDecoder (
    .instructionType(instructionType), .instructionSubType(instructionSubType),
    .zero(zero), .resultSrc(resultSrc), .aluSrc(aluSrc), .pcSrc(pcSrc),
    .regWrite(regWrite), .memWrite(memWrite)
  );

  AluEncode aluEncoder (.instructionType(instructionType),
                        .instructionSubType(instructionSubType), .aluControl(aluControl));

endmodule

//--- hdl/DataPath.sv
`include "Core_consts.svh"

module DataPath (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  input  logic [4:0]              rd,
  input  logic [`XLEN-1:0]        immExt,
  input  CoreTypes::AluOps        aluControl,
  input  CoreTypes::ResultSources resultSrc,
  input  logic                    aluSrc,
  input  logic                    pcSrc,
  input  logic                    regWrite,
  input  logic [`XLEN-1:0]        memReadData,
  output logic [`XLEN-1:0]        pc,
  output logic [`XLEN-1:0]        aluResult,
  output logic [`XLEN-1:0]        writeData,
  output logic                    zero
);
  import CoreTypes::*;

  // ##########################################################################
  // program counter
  // ##########################################################################

  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] pcTarget;  // branch / jal destination

  assign pcPlus4  = pc + `XLEN'd4;
  assign pcTarget = pc + immExt;

  always_ff @(posedge clk) begin
    if (rst) pc <= '0;  // held at zero through reset
    else     pc <= pcSrc ? pcTarget : pcPlus4;
  end

  // ##########################################################################
  // register file
  // ##########################################################################

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic [`XLEN-1:0] readData1;
  logic [`XLEN-1:0] readData2;
  logic [`XLEN-1:0] result;  // write-back value

  // x0 reads as zero whatever the array holds
  assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];
  assign writeData = readData2;  // store data

  always_ff @(posedge clk) begin
    if (!rst && regWrite && rd != 5'd0) regs[rd] <= result;
  end

  // ##########################################################################
  // alu
  // ##########################################################################

  logic [`XLEN-1:0] srcB;
  logic [4:0]       shamt;  // low five bits only

  assign srcB  = aluSrc ? immExt : readData2;
  assign shamt = srcB[4:0];

  always_comb begin
    case (aluControl)
      AluAdd:   aluResult = readData1 + srcB;
      AluSub:   aluResult = readData1 - srcB;
      AluAnd:   aluResult = readData1 & srcB;
      AluOr:    aluResult = readData1 | srcB;
      AluXor:   aluResult = readData1 ^ srcB;
      AluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(readData1) < $signed(srcB)};
      AluSll:   aluResult = readData1 << shamt;
      AluSrl:   aluResult = readData1 >> shamt;
      AluSra:   aluResult = $unsigned($signed(readData1) >>> shamt);  // sign fill
      AluPassB: aluResult = srcB;
      default:  aluResult = '0;
    endcase
  end

  assign zero = (aluResult == '0);  // equality test for branches

  // write-back select
  always_comb begin
    case (resultSrc)
      ResMem:     result = memReadData;
      ResPcPlus4: result = pcPlus4;   // jal link
      ResImm:     result = immExt;    // lui
      default:    result = aluResult;
    endcase
  end

endmodule

//--- hdl/RiscvCore.sv
`include "Core_consts.svh"

module RiscvCore (
  input  logic              clk,
  input  logic              rst,
  input  logic [`XLEN-1:0]  instruction,
  output logic [`XLEN-1:0]  pc,
  output logic [`XLEN-1:0]  memAddr,
  output logic [`XLEN-1:0]  memWriteData,
  output logic              memWrite,
  input  logic [`XLEN-1:0]  memReadData
);

  logic [4:0]              rs1, rs2, rd;
  logic [`XLEN-1:0]        immExt;
  CoreTypes::AluOps        aluControl;
  CoreTypes::ResultSources resultSrc;
  logic                    aluSrc, pcSrc, regWrite, zero;
  logic                    decodedMemWrite;  // before the reset gate

  ControlPath controlUnit (
    .instruction(instruction), .zero(zero), .immExt(immExt), .aluControl(aluControl),
    .resultSrc(resultSrc), .aluSrc(aluSrc), .pcSrc(pcSrc), .memWrite(decodedMemWrite),
    .regWrite(regWrite), .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  DataPath dataUnit (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .immExt(immExt),
    .aluControl(aluControl), .resultSrc(resultSrc), .aluSrc(aluSrc), .pcSrc(pcSrc),
    .regWrite(regWrite), .memReadData(memReadData), .pc(pc),
    .aluResult(memAddr),         // effective address for lw / sw
    .writeData(memWriteData), .zero(zero)
  );

  assign memWrite = decodedMemWrite & ~rst;  // no stores while in reset

endmodule

//--- test/RiscvCore_sva.sv
`include "Core_consts.svh"

module RiscvCore_sva (
  input logic             clk,
  input logic             rst,
  input logic [`XLEN-1:0] pc,
  input logic             memWrite
);
  timeunit 1ns;
  timeprecision 1ps;

  // no store may leave the core while it is held in reset
  noStoreInReset: assert property (@(posedge clk) rst |-> !memWrite)
    else $error("memWrite high while rst is asserted");

  pcWordAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // first cycle out of reset fetches from address 0
  pcZeroAfterReset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
    else $error("pc is not zero in the cycle after reset");

endmodule

bind RiscvCore RiscvCore_sva coreChecks (.clk(clk), .rst(rst), .pc(pc), .memWrite(memWrite));

//--- test/RiscvCore_tb.sv
`include "Core_consts.svh"

module RiscvCore_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ImemBits = $clog2(`IMEM_WORDS);
  localparam int DmemBits = $clog2(`DMEM_WORDS);

  typedef struct {
    string            name;
    logic [`XLEN-1:0] instr;
    bit               store;  // row is a sw that must reach memory
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] data;
  } ProgramRow;

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] instruction;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] memAddr;
  logic [`XLEN-1:0] memWriteData;
  logic             memWrite;
  logic [`XLEN-1:0] memReadData;

  logic [`XLEN-1:0] imem [`IMEM_WORDS];
  logic [`XLEN-1:0] dmem [`DMEM_WORDS];
  ProgramRow        rows [$];
  int               storeRows [$];  // row indices of the expected stores in program order
  int               storeCursor;    // next expected store
  int               cycles;
  int               cycleLimit;
  logic [`XLEN-1:0] lastPc;         // address of the final self jump

  RiscvCore u_RiscvCore (
    .clk(clk), .rst(rst), .instruction(instruction), .pc(pc), .memAddr(memAddr),
    .memWriteData(memWriteData), .memWrite(memWrite), .memReadData(memReadData)
  );

  always #5 clk = ~clk;

  // both memories read combinationally by word address
  assign instruction = imem[pc[ImemBits+1:2]];
  assign memReadData = dmem[memAddr[DmemBits+1:2]];

  always @(posedge clk) begin
    if (memWrite) dmem[memAddr[DmemBits+1:2]] <= memWriteData;
  end

  // ##########################################################################
  // helpers
  // ##########################################################################

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic addRow(input string name, input logic [`XLEN-1:0] instr, input bit store,
                        input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
    ProgramRow row;
    row.name  = name;
    row.instr = instr;
    row.store = store;
    row.addr  = addr;
    row.data  = data;
    rows.push_back(row);
  endtask

  // x1 = 12, x2 = -5, x9 = 3 are the shared operands
  task automatic loadTable();
    addRow("sw in reset", 32'h08002423, 1'b1, 32'h88, 32'h0000_0000);  // sw x0, 136(x0)
    addRow("set x1",      32'h00C00093, 1'b0, 32'h0,  32'h0);          // addi x1, x0, 12
    addRow("addi neg",    32'hFFB00113, 1'b0, 32'h0,  32'h0);          // addi x2, x0, -5
    addRow("add",         32'h002081B3, 1'b0, 32'h0,  32'h0);          // add x3, x1, x2
    addRow("sw add",      32'h04302023, 1'b1, 32'h40, 32'h0000_0007);  // sw x3, 64(x0)
    addRow("sub",         32'h40208233, 1'b0, 32'h0,  32'h0);          // sub x4, x1, x2
    addRow("sw sub",      32'h04402223, 1'b1, 32'h44, 32'h0000_0011);  // 12 - -5
    addRow("and",         32'h0020F2B3, 1'b0, 32'h0,  32'h0);          // and x5, x1, x2
    addRow("sw and",      32'h04502423, 1'b1, 32'h48, 32'h0000_0008);
    addRow("or",          32'h0020E333, 1'b0, 32'h0,  32'h0);          // or x6, x1, x2
    addRow("sw or",       32'h04602623, 1'b1, 32'h4C, 32'hFFFF_FFFF);
    addRow("xor",         32'h0020C3B3, 1'b0, 32'h0,  32'h0);          // xor x7, x1, x2
    addRow("sw xor",      32'h04702823, 1'b1, 32'h50, 32'hFFFF_FFF7);
    addRow("slt",         32'h00112433, 1'b0, 32'h0,  32'h0);          // slt x8, x2, x1
    addRow("sw slt",      32'h04802A23, 1'b1, 32'h54, 32'h0000_0001);  // -5 < 12 signed
    addRow("set x9",      32'h00300493, 1'b0, 32'h0,  32'h0);          // addi x9, x0, 3
    addRow("sll",         32'h00909533, 1'b0, 32'h0,  32'h0);          // sll x10, x1, x9
    addRow("sw sll",      32'h04A02C23, 1'b1, 32'h58, 32'h0000_0060);
    addRow("srl",         32'h009155B3, 1'b0, 32'h0,  32'h0);          // srl x11, x2, x9
    addRow("sw srl",      32'h04B02E23, 1'b1, 32'h5C, 32'h1FFF_FFFF);  // zero fill
    addRow("sra",         32'h40915633, 1'b0, 32'h0,  32'h0);          // sra x12, x2, x9
    addRow("sw sra",      32'h06C02023, 1'b1, 32'h60, 32'hFFFF_FFFF);  // sign fill
    addRow("andi",        32'h0F017693, 1'b0, 32'h0,  32'h0);          // andi x13, x2, 0xf0
    addRow("sw andi",     32'h06D02223, 1'b1, 32'h64, 32'h0000_00F0);
    addRow("ori",         32'h3000E713, 1'b0, 32'h0,  32'h0);          // ori x14, x1, 0x300
    addRow("sw ori",      32'h06E02423, 1'b1, 32'h68, 32'h0000_030C);
    addRow("xori",        32'hFFF0C793, 1'b0, 32'h0,  32'h0);          // xori x15, x1, -1
    addRow("sw xori",     32'h06F02623, 1'b1, 32'h6C, 32'hFFFF_FFF3);
    addRow("slti",        32'hFFC12813, 1'b0, 32'h0,  32'h0);          // slti x16, x2, -4
    addRow("sw slti",     32'h07002823, 1'b1, 32'h70, 32'h0000_0001);
    addRow("lui",         32'h123458B7, 1'b0, 32'h0,  32'h0);          // lui x17, 0x12345
    addRow("sw lui",      32'h07102A23, 1'b1, 32'h74, 32'h1234_5000);
    addRow("lw",          32'h07402903, 1'b0, 32'h0,  32'h0);          // lw x18, 116(x0)
    addRow("sw lw back",  32'h07202C23, 1'b1, 32'h78, 32'h1234_5000);
    addRow("beq taken",   32'h00108463, 1'b0, 32'h0,  32'h0);          // beq x1, x1, +8
    addRow("beq skipped", 32'h06302E23, 1'b0, 32'h0,  32'h0);          // must not store
    addRow("bne taken",   32'h00209463, 1'b0, 32'h0,  32'h0);          // bne x1, x2, +8
    addRow("bne skipped", 32'h06202E23, 1'b0, 32'h0,  32'h0);          // must not store
    addRow("beq untaken", 32'h00208463, 1'b0, 32'h0,  32'h0);          // beq x1, x2, +8
    addRow("sw fall thru",32'h06102E23, 1'b1, 32'h7C, 32'h0000_000C);  // sw x1, 124(x0)
    addRow("jal",         32'h008009EF, 1'b0, 32'h0,  32'h0);          // jal x19, +8 at 0xa0
    addRow("jal skipped", 32'h08102023, 1'b0, 32'h0,  32'h0);          // must not store
    addRow("sw jal link", 32'h09302023, 1'b1, 32'h80, 32'h0000_00A4);  // 0xa0 + 4
    addRow("write x0",    32'h00500013, 1'b0, 32'h0,  32'h0);          // addi x0, x0, 5
    addRow("sw x0",       32'h08002223, 1'b1, 32'h84, 32'h0000_0000);
    addRow("halt",        32'h0000006F, 1'b0, 32'h0,  32'h0);          // jal x0, 0
  endtask

  task automatic checkStore();
    ProgramRow expRow;
    assert (storeCursor < storeRows.size())
      else abortRun($sformatf("unexpected store of %h to address %h", memWriteData, memAddr));
    expRow = rows[storeRows[storeCursor]];
    assert (memAddr == expRow.addr)
      else abortRun($sformatf("MISMATCH %s address expected %h actual %h",
                              expRow.name, expRow.addr, memAddr));
    assert (memWriteData == expRow.data)
      else abortRun($sformatf("MISMATCH %s data expected %h actual %h",
                              expRow.name, expRow.data, memWriteData));
    storeCursor++;
  endtask

  task automatic finishRun();
    if (storeCursor == storeRows.size()) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abortRun($sformatf("program halted but the store of row %s never happened",
                         rows[storeRows[storeCursor]].name));
    end
  endtask

  // ##########################################################################
  // stimulus and checking
  // ##########################################################################

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    storeCursor = 0;
    cycles      = 0;
    loadTable();
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      imem[i] = {25'(i), 7'h00};  // opcode 0 decodes as illegal
    end
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      dmem[i] = {16'hDA7A, 16'(i)};
    end
    for (int i = 0; i < rows.size(); i++) begin
      imem[i] = rows[i].instr;
      if (rows[i].store) storeRows.push_back(i);
    end
    lastPc     = 32'((rows.size() - 1) * 4);
    cycleLimit = 4 * rows.size() + 50;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

  // outputs are sampled before this edge commits anything
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      abortRun($sformatf("timeout after %0d cycles without reaching the final jump", cycles));
    end else if (!rst) begin
      if (memWrite) checkStore();
      if (pc == lastPc) finishRun();  // self jump reached
    end
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/CoreTypes.sv
hdl/InstructionDecode.sv
hdl/ImmDecode.sv
hdl/ControlDecode.sv
hdl/AluEncode.sv
hdl/ControlPath.sv
hdl/DataPath.sv
hdl/RiscvCore.sv
test/RiscvCore_sva.sv
test/RiscvCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the RiscvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module RiscvCore_tb -o simv

# a stop on error exits nonzero, so keep the status and search the log
simStatus=0
./obj_dir/simv > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || [ "$simStatus" -ne 0 ]; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run finished cleanly"
